// File: pattern_driver_top.f
+incdir+rtl
rtl/pattern_cmd_pkg.sv
rtl/pattern_bank_pkg.sv
rtl/spi_receiver.sv
rtl/command_decoder.sv
rtl/step_sequencer.sv
rtl/pattern_bank.sv
rtl/pattern_driver_top.sv
verif/tb_clock_gen.sv
verif/pattern_driver_chk.sv
verif/pattern_driver_tb.sv

// File: rtl/command_decoder.sv
/*
 * turns accepted SPI words into memory writes and configuration.
 * out-of-range driver indexes and step addresses are dropped here, not in the bank.
 * a last step address past the memory is clamped to the final entry.
 */
`timescale 1ns/1ps
`include "pattern_driver_params.svh"

module command_decoder (
  input  logic                          clock_i,
  input  logic                          arst_n_i,
  input  logic                          word_valid_i,
  input  logic [`SPI_WORD_W-1:0]        word_i,
  output logic                          wr_en_o,
  output pattern_bank_pkg::driver_idx_t wr_driver_o,
  output pattern_bank_pkg::step_addr_t  wr_addr_o,
  output pattern_bank_pkg::step_data_t  wr_data_o,
  output logic [`NUM_DRIVERS-1:0]       invert_o,
  output pattern_bank_pkg::step_addr_t  last_addr_o
);

  pattern_cmd_pkg::cmd_word_u cmd;
  logic                       is_config;
  logic                       wr_ok;
  logic                       cfg_ok;

  assign cmd       = pattern_cmd_pkg::cmd_word_u'(word_i);
  assign is_config = (cmd.wr.kind == pattern_cmd_pkg::CONFIG);

  assign wr_ok  = word_valid_i && !is_config && (cmd.wr.driver < `NUM_DRIVERS)
                  && (cmd.wr.addr < `MEM_LENGTH);
  assign cfg_ok = word_valid_i && is_config && (cmd.cfg.driver < `NUM_DRIVERS);

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_en_o     <= 1'b0;
      invert_o    <= '0;
      last_addr_o <= pattern_bank_pkg::step_addr_t'(`MEM_LENGTH - 1);
    end else begin
      wr_en_o <= wr_ok;
      if (cfg_ok) begin
        invert_o[cmd.cfg.driver] <= cmd.cfg.invert;
        if (cmd.cfg.last_addr >= `MEM_LENGTH) begin
          last_addr_o <= pattern_bank_pkg::step_addr_t'(`MEM_LENGTH - 1);
        end else begin
          last_addr_o <= cmd.cfg.last_addr;
        end
      end
    end
  end

  // write payload, qualified by wr_en_o
  always_ff @(posedge clock_i) begin
    if (wr_ok) begin
      wr_driver_o <= cmd.wr.driver;
      wr_addr_o   <= cmd.wr.addr;
      wr_data_o   <= cmd.wr.data;
    end
  end

endmodule

// File: rtl/pattern_bank.sv
/*
 * one pattern memory per driver, all read at the same step address.
 * write indexes are assumed in range; the decoder filters them.
 * outputs are registered and forced to zero outside a playback.
 */
`timescale 1ns/1ps
`include "pattern_driver_params.svh"

module pattern_bank (
  input  logic                                        clock_i,
  input  logic                                        arst_n_i,
  input  logic                                        wr_en_i,
  input  pattern_bank_pkg::driver_idx_t               wr_driver_i,
  input  pattern_bank_pkg::step_addr_t                wr_addr_i,
  input  pattern_bank_pkg::step_data_t                wr_data_i,
  input  logic [`NUM_DRIVERS-1:0]                     invert_i,
  input  logic                                        step_valid_i,
  input  pattern_bank_pkg::step_addr_t                step_addr_i,
  output logic [`NUM_DRIVERS*`OUTS_PER_DRIVER-1:0]    driver_io_o
);

  pattern_bank_pkg::step_data_t               mem_q [`NUM_DRIVERS][`MEM_LENGTH];
  logic [`NUM_DRIVERS*`OUTS_PER_DRIVER-1:0]   step_word;

  always_ff @(posedge clock_i) begin
    if (wr_en_i) begin
      mem_q[wr_driver_i][wr_addr_i] <= wr_data_i;
    end
  end

  // read every driver at the current step, invert per driver on all its pins
  always_comb begin
    for (int d = 0; d < `NUM_DRIVERS; d++) begin
      step_word[d*`OUTS_PER_DRIVER +: `OUTS_PER_DRIVER] =
        mem_q[d][step_addr_i] ^ {`OUTS_PER_DRIVER{invert_i[d]}};
    end
  end

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      driver_io_o <= '0;
    end else if (step_valid_i) begin
      driver_io_o <= step_word;
    end else begin
      driver_io_o <= '0;
    end
  end

endmodule

// File: rtl/pattern_bank_pkg.sv
/*
 * index, address and data types of the pattern memories.
 */
`include "pattern_driver_params.svh"

package pattern_bank_pkg;

  // wide enough for NUM_DRIVERS
  typedef logic [3:0] driver_idx_t;

  typedef logic [`MEM_ADDR_W-1:0] step_addr_t;

  // one value per output pin of a driver
  typedef logic [`OUTS_PER_DRIVER-1:0] step_data_t;

endpackage

// File: rtl/pattern_cmd_pkg.sv
/*
 * 32-bit SPI command word layout. bit 31 selects the view.
 * unused bits are ignored by the decoder.
 */
`include "pattern_driver_params.svh"

package pattern_cmd_pkg;

  typedef enum logic {
    PATTERN_WRITE = 1'b0,
    CONFIG        = 1'b1
  } cmd_kind_e;

  // one step into one driver memory
  typedef struct packed {
    cmd_kind_e                    kind;
    logic [3:0]                   driver;
    logic [`MEM_ADDR_W-1:0]       addr;
    logic [18:0]                  unused;
    logic [`OUTS_PER_DRIVER-1:0]  data;
  } pattern_write_t;

  // invert bit for one driver plus the shared sequence length
  typedef struct packed {
    cmd_kind_e                    kind;
    logic [3:0]                   driver;
    logic [`MEM_ADDR_W-1:0]       last_addr;
    logic                         invert;
    logic [19:0]                  unused;
  } config_t;

  typedef union packed {
    pattern_write_t               wr;
    config_t                      cfg;
    logic [`SPI_WORD_W-1:0]       raw;
  } cmd_word_u;

endpackage

// File: rtl/pattern_driver_params.svh
/*
 * counts and widths shared by the pattern driver RTL and packages.
 * MEM_ADDR_W must cover MEM_LENGTH-1; the driver index field is fixed at 4 bits.
 */
`ifndef PATTERN_DRIVER_PARAMS_SVH
`define PATTERN_DRIVER_PARAMS_SVH

// driver channels and pins per channel
`define NUM_DRIVERS 10
`define OUTS_PER_DRIVER 2

// pattern steps per driver
`define MEM_LENGTH 48
`define MEM_ADDR_W 6

// one SPI frame
`define SPI_WORD_W 32

// flops in each input synchronizer
`define SYNC_STAGES 2

`endif

// File: rtl/pattern_driver_top.sv
/*
 * ten-channel pattern driver: SPI receive, decode, sequence, bank.
 * everything runs on clock_i; all control inputs are asynchronous to it.
 */
`timescale 1ns/1ps
`include "pattern_driver_params.svh"

module pattern_driver_top (
  input  logic                                     clock_i,
  input  logic                                     arst_n_i,
  input  logic                                     sclk_i,
  input  logic                                     mosi_i,
  input  logic                                     ss_n_i,
  input  logic                                     trigger_i,
  output logic                                     miso_o,
  output logic [`NUM_DRIVERS*`OUTS_PER_DRIVER-1:0] driver_io_o,
  output logic                                     update_cycle_complete_o
);

  logic                          word_valid;
  logic [`SPI_WORD_W-1:0]        word;
  logic                          wr_en;
  pattern_bank_pkg::driver_idx_t wr_driver;
  pattern_bank_pkg::step_addr_t  wr_addr;
  pattern_bank_pkg::step_data_t  wr_data;
  logic [`NUM_DRIVERS-1:0]       invert;
  pattern_bank_pkg::step_addr_t  last_addr;
  logic                          step_valid;
  pattern_bank_pkg::step_addr_t  step_addr;

  spi_receiver spi_receiver_i (
    .clock_i      (clock_i),
    .arst_n_i     (arst_n_i),
    .sclk_i       (sclk_i),
    .mosi_i       (mosi_i),
    .ss_n_i       (ss_n_i),
    .miso_o       (miso_o),
    .word_valid_o (word_valid),
    .word_o       (word)
  );

  command_decoder command_decoder_i (
    .clock_i      (clock_i),
    .arst_n_i     (arst_n_i),
    .word_valid_i (word_valid),
    .word_i       (word),
    .wr_en_o      (wr_en),
    .wr_driver_o  (wr_driver),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data),
    .invert_o     (invert),
    .last_addr_o  (last_addr)
  );

  step_sequencer step_sequencer_i (
    .clock_i                 (clock_i),
    .arst_n_i                (arst_n_i),
    .trigger_i               (trigger_i),
    .last_addr_i             (last_addr),
    .step_valid_o            (step_valid),
    .step_addr_o             (step_addr),
    .update_cycle_complete_o (update_cycle_complete_o)
  );

  pattern_bank pattern_bank_i (
    .clock_i      (clock_i),
    .arst_n_i     (arst_n_i),
    .wr_en_i      (wr_en),
    .wr_driver_i  (wr_driver),
    .wr_addr_i    (wr_addr),
    .wr_data_i    (wr_data),
    .invert_i     (invert),
    .step_valid_i (step_valid),
    .step_addr_i  (step_addr),
    .driver_io_o  (driver_io_o)
  );

endmodule

// File: rtl/spi_receiver.sv
/*
 * SPI mode 0 slave, MSB first, oversampled by clock_i.
 * sclk high and low times must each be at least 4 clock cycles.
 * only frames of exactly SPI_WORD_W bits are accepted; miso replays the last one.
 */
`timescale 1ns/1ps
`include "pattern_driver_params.svh"

module spi_receiver (
  input  logic                   clock_i,
  input  logic                   arst_n_i,
  input  logic                   sclk_i,
  input  logic                   mosi_i,
  input  logic                   ss_n_i,
  output logic                   miso_o,
  output logic                   word_valid_o,
  output logic [`SPI_WORD_W-1:0] word_o
);

  localparam int CNT_W = $clog2(`SPI_WORD_W) + 1;

  // pins packed as {sclk, mosi, ss_n}, oldest stage at the top
  logic [`SYNC_STAGES-1:0][2:0] pin_sync_q;
  logic                         sclk_s;
  logic                         mosi_s;
  logic                         ss_n_s;
  logic                         sclk_prev_q;
  logic                         ss_n_prev_q;
  logic                         sclk_rise;
  logic                         sclk_fall;
  logic                         ss_fall;
  logic                         ss_rise;
  logic [`SPI_WORD_W-1:0]       shift_q;
  logic [CNT_W-1:0]             bit_cnt_q;
  logic [`SPI_WORD_W-1:0]       word_q;
  logic [`SPI_WORD_W-1:0]       readback_q;
  logic                         valid_q;

  assign {sclk_s, mosi_s, ss_n_s} = pin_sync_q[`SYNC_STAGES-1];

  assign sclk_rise = sclk_s & ~sclk_prev_q;
  assign sclk_fall = ~sclk_s & sclk_prev_q;
  assign ss_fall   = ~ss_n_s & ss_n_prev_q;
  assign ss_rise   = ss_n_s & ~ss_n_prev_q;

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // idle bus has ss_n high
      pin_sync_q  <= {`SYNC_STAGES{3'b001}};
      sclk_prev_q <= 1'b0;
      ss_n_prev_q <= 1'b1;
      shift_q     <= '0;
      bit_cnt_q   <= '0;
      word_q      <= '0;
      readback_q  <= '0;
      valid_q     <= 1'b0;
    end else begin
      pin_sync_q  <= {pin_sync_q[`SYNC_STAGES-2:0], {sclk_i, mosi_i, ss_n_i}};
      sclk_prev_q <= sclk_s;
      ss_n_prev_q <= ss_n_s;
      valid_q     <= 1'b0;

      if (ss_fall) begin
        bit_cnt_q  <= '0;
        readback_q <= word_q;
      end else if (!ss_n_s) begin
        if (sclk_rise) begin
          shift_q <= {shift_q[`SPI_WORD_W-2:0], mosi_s};
          // saturate so long frames never wrap back to a valid count
          if (bit_cnt_q != {CNT_W{1'b1}}) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end
        end
        if (sclk_fall) begin
          readback_q <= {readback_q[`SPI_WORD_W-2:0], 1'b0};
        end
      end

      if (ss_rise && bit_cnt_q == CNT_W'(`SPI_WORD_W)) begin
        valid_q <= 1'b1;
        word_q  <= shift_q;
      end
    end
  end

  assign miso_o       = readback_q[`SPI_WORD_W-1];
  assign word_valid_o = valid_q;
  assign word_o       = word_q;

endmodule

// File: rtl/step_sequencer.sv
/*
 * steps the pattern address from 0 to last_addr once per trigger rising edge.
 * trigger edges arriving while a cycle runs are ignored.
 * the complete pulse is delayed to line up with the bank's registered output.
 */
`timescale 1ns/1ps
`include "pattern_driver_params.svh"

module step_sequencer (
  input  logic                         clock_i,
  input  logic                         arst_n_i,
  input  logic                         trigger_i,
  input  pattern_bank_pkg::step_addr_t last_addr_i,
  output logic                         step_valid_o,
  output pattern_bank_pkg::step_addr_t step_addr_o,
  output logic                         update_cycle_complete_o
);

  logic [`SYNC_STAGES-1:0]      trig_sync_q;
  logic                         trig_prev_q;
  logic                         trig_rise;
  logic                         running_q;
  pattern_bank_pkg::step_addr_t addr_q;
  pattern_bank_pkg::step_addr_t last_q;
  logic                         last_step;
  logic [1:0]                   done_q;

  assign trig_rise = trig_sync_q[`SYNC_STAGES-1] & ~trig_prev_q;
  assign last_step = running_q && (addr_q == last_q);

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      trig_sync_q <= '0;
      trig_prev_q <= 1'b0;
      running_q   <= 1'b0;
      addr_q      <= '0;
      last_q      <= '0;
      done_q      <= '0;
    end else begin
      trig_sync_q <= {trig_sync_q[`SYNC_STAGES-2:0], trigger_i};
      trig_prev_q <= trig_sync_q[`SYNC_STAGES-1];

      if (!running_q) begin
        if (trig_rise) begin
          // length is frozen for the whole cycle
          running_q <= 1'b1;
          addr_q    <= '0;
          last_q    <= last_addr_i;
        end
      end else if (last_step) begin
        running_q <= 1'b0;
      end else begin
        addr_q <= addr_q + 1'b1;
      end

      // one stage for the bank read, one for its output register
      done_q <= {done_q[0], last_step};
    end
  end

  assign step_valid_o            = running_q;
  assign step_addr_o             = addr_q;
  assign update_cycle_complete_o = done_q[1];

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the pattern driver testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f pattern_driver_top.f \
  --top-module pattern_driver_tb \
  -o Vpattern_driver_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build returned status $status"
  exit 1
fi

./obj_dir/Vpattern_driver_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if grep -q "Checks failed" "$LOG"; then
  exit 1
fi
exit 0

// File: verif/pattern_driver_chk.sv
/*
 * protocol assertions on the pattern driver top level, attached by bind.
 * trigger edges are taken as seen at the pin, so the age bound includes sync delay.
 */
`timescale 1ns/1ps
`include "pattern_driver_params.svh"

module pattern_driver_chk (
  input logic                                     clock_i,
  input logic                                     arst_n_i,
  input logic                                     trigger_i,
  input logic [`NUM_DRIVERS*`OUTS_PER_DRIVER-1:0] driver_io_i,
  input logic                                     complete_i
);

  logic       trig_prev_q;
  logic [5:0] edge_age_q;

  // cycles since the last trigger rise, saturating
  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      trig_prev_q <= 1'b0;
      edge_age_q  <= '1;
    end else begin
      trig_prev_q <= trigger_i;
      if (trigger_i && !trig_prev_q) begin
        edge_age_q <= '0;
      end else if (edge_age_q != '1) begin
        edge_age_q <= edge_age_q + 1'b1;
      end
    end
  end

  complete_single_cycle: assert property (
    @(posedge clock_i) disable iff (!arst_n_i) complete_i |=> !complete_i
  ) else $error("update complete pulse lasted more than one cycle");

  outputs_low_in_reset: assert property (
    @(posedge clock_i) !arst_n_i |-> (driver_io_i == '0 && !complete_i)
  ) else $error("outputs not low during reset");

  complete_after_trigger: assert property (
    @(posedge clock_i) disable iff (!arst_n_i) complete_i |-> (edge_age_q <= 6'd52)
  ) else $error("update complete pulse without a trigger edge in the last 52 cycles");

endmodule

bind pattern_driver_top pattern_driver_chk pattern_driver_chk_i (
  .clock_i     (clock_i),
  .arst_n_i    (arst_n_i),
  .trigger_i   (trigger_i),
  .driver_io_i (driver_io_o),
  .complete_i  (update_cycle_complete_o)
);

// File: verif/pattern_driver_tb.sv
/*
 * table-driven testbench for the pattern driver, with its own model of the
 * command decoding. every pattern entry is written before the first trigger.
 */
`timescale 1ns/1ps
`include "pattern_driver_params.svh"

module pattern_driver_tb;

  typedef enum logic [1:0] {FRAME, SHORT_FRAME, TRIGGER} entry_kind_e;

  // word holds the command, or for a trigger the cycle of a second edge
  typedef struct packed {
    entry_kind_e kind;
    logic [31:0] word;
    logic [31:0] readback;
  } entry_t;

  logic                                     clock;
  logic                                     arst_n;
  logic                                     sclk;
  logic                                     mosi;
  logic                                     ss_n;
  logic                                     trigger;
  logic                                     miso;
  logic [`NUM_DRIVERS*`OUTS_PER_DRIVER-1:0] driver_io;
  logic                                     complete;

  entry_t                       table_q [$];
  logic [31:0]                  last_accepted;
  bit                           table_ready;
  int                           seed;
  int                           errors;
  int                           failed_tests;
  int                           errs_before;
  logic [31:0]                  rb;
  logic [31:0]                  exp_rb;
  pattern_bank_pkg::step_data_t model_mem [`NUM_DRIVERS][`MEM_LENGTH];
  logic [`NUM_DRIVERS-1:0]      model_inv;
  pattern_bank_pkg::step_addr_t model_last;

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(5)) tb_clock_gen_i (
    .clock_o  (clock),
    .arst_n_o (arst_n)
  );

  pattern_driver_top pattern_driver_top_i (
    .clock_i                 (clock),
    .arst_n_i                (arst_n),
    .sclk_i                  (sclk),
    .mosi_i                  (mosi),
    .ss_n_i                  (ss_n),
    .trigger_i               (trigger),
    .miso_o                  (miso),
    .driver_io_o             (driver_io),
    .update_cycle_complete_o (complete)
  );

  function automatic logic [31:0] write_word(int drv, int addr, logic [1:0] data);
    pattern_cmd_pkg::pattern_write_t w;
    w        = '0;
    w.kind   = pattern_cmd_pkg::PATTERN_WRITE;
    w.driver = drv[3:0];
    w.addr   = addr[5:0];
    w.data   = data;
    return w;
  endfunction

  function automatic logic [31:0] config_word(int drv, int last, logic inv);
    pattern_cmd_pkg::config_t c;
    c           = '0;
    c.kind      = pattern_cmd_pkg::CONFIG;
    c.driver    = drv[3:0];
    c.last_addr = last[5:0];
    c.invert    = inv;
    return c;
  endfunction

  // readback is the last word of a full frame before this entry
  task automatic add_entry(input entry_kind_e kind, input logic [31:0] word);
    table_q.push_back(entry_t'{kind: kind, word: word, readback: last_accepted});
    if (kind == FRAME) begin
      last_accepted = word;
    end
  endtask

  task automatic build_table();
    logic [31:0] r;
    logic [1:0]  kept;
    last_accepted = '0;
    kept          = '0;
    for (int d = 0; d < `NUM_DRIVERS; d++) begin
      for (int a = 0; a < `MEM_LENGTH; a++) begin
        r = $random(seed);
        if (d == 0 && a == 5) kept = r[1:0];
        add_entry(FRAME, write_word(d, a, r[1:0]));
      end
    end
    // out-of-range driver and address
    add_entry(FRAME, write_word(11, 3, 2'b11));
    add_entry(FRAME, write_word(2, 50, 2'b11));
    add_entry(TRIGGER, 32'd0);
    add_entry(FRAME, config_word(1, 11, 1'b1));
    add_entry(FRAME, config_word(4, 11, 1'b1));
    add_entry(FRAME, config_word(9, 11, 1'b1));
    add_entry(FRAME, config_word(12, 3, 1'b1));
    add_entry(TRIGGER, 32'd0);
    add_entry(SHORT_FRAME, write_word(0, 5, ~kept));
    // last step past the memory clamps to 47
    add_entry(FRAME, config_word(1, 63, 1'b0));
    add_entry(TRIGGER, 32'd20);
    add_entry(TRIGGER, 32'd0);
  endtask

  task automatic update_model(input logic [31:0] word);
    if (word[31] == 1'b0) begin
      if (word[30:27] < `NUM_DRIVERS && word[26:21] < `MEM_LENGTH) begin
        model_mem[word[30:27]][word[26:21]] = word[1:0];
      end
    end else if (word[30:27] < `NUM_DRIVERS) begin
      model_inv[word[30:27]] = word[20];
      model_last = (word[26:21] >= `MEM_LENGTH) ? 6'(`MEM_LENGTH - 1) : word[26:21];
    end
  endtask

  function automatic logic [19:0] expected_io(int k);
    logic [19:0] v;
    for (int d = 0; d < `NUM_DRIVERS; d++) begin
      v[2*d +: 2] = model_mem[d][k] ^ {2{model_inv[d]}};
    end
    return v;
  endfunction

  // mode 0 frame, sclk half period of 5 cycles, miso sampled before each rise
  task automatic send_frame(input logic [31:0] word, input int nbits, output logic [31:0] got);
    got = '0;
    @(posedge clock);
    ss_n <= 1'b0;
    repeat (5) @(posedge clock);
    for (int i = 31; i > 31 - nbits; i--) begin
      mosi <= word[i];
      repeat (4) @(posedge clock);
      @(negedge clock);
      got = {got[30:0], miso};
      @(posedge clock);
      sclk <= 1'b1;
      repeat (5) @(posedge clock);
      sclk <= 1'b0;
    end
    repeat (5) @(posedge clock);
    ss_n <= 1'b1;
    repeat (8) @(posedge clock);
  endtask

  task automatic play_trigger(input int second_at);
    logic [19:0] trace_q [$];
    int          cycles;
    bit          done;
    int          n;
    int          base;
    logic [19:0] exp;
    n      = int'(model_last) + 1;
    cycles = 0;
    done   = 0;
    while (!done && cycles < 200) begin
      @(posedge clock);
      if (cycles == 0 || (second_at > 0 && cycles == second_at)) trigger <= 1'b1;
      if (cycles == 4 || (second_at > 0 && cycles == second_at + 4)) trigger <= 1'b0;
      @(negedge clock);
      if (complete) done = 1;
      else trace_q.push_back(driver_io);
      cycles++;
    end
    @(posedge clock);
    trigger <= 1'b0;
    assert (done) else begin
      $display("no update complete pulse within 200 cycles of the trigger edge");
      errors++;
    end
    if (done) begin
      // three cycles of trigger sync plus the bank register ahead of step 0
      assert (trace_q.size() == n + 4) else begin
        $display("complete pulse came %0d cycles after the trigger edge, %0d expected",
                 trace_q.size(), n + 4);
        errors++;
      end
      base = trace_q.size() - n;
      for (int j = 0; j < base; j++) begin
        assert (trace_q[j] == '0) else begin
          $display("[ERROR] %0t ns driver_io_o before step 0: got %h expected %h",
                   $time, trace_q[j], 20'h0);
          errors++;
        end
      end
      for (int k = 0; k < n && base >= 0; k++) begin
        exp = expected_io(k);
        assert (trace_q[base + k] == exp) else begin
          $display("[ERROR] %0t ns driver_io_o step %0d: got %h expected %h",
                   $time, k, trace_q[base + k], exp);
          errors++;
        end
      end
      // nothing may follow the single complete pulse
      repeat (60) begin
        @(negedge clock);
        assert (!complete && driver_io == '0) else begin
          $display("[ERROR] %0t ns complete/driver_io_o after playback: got %b/%h expected 0/0",
                   $time, complete, driver_io);
          errors++;
        end
      end
    end
  endtask

  initial begin
    sclk    = 1'b0;
    mosi    = 1'b0;
    ss_n    = 1'b1;
    trigger = 1'b0;
  end

  initial begin
    wait (table_ready);
    repeat (table_q.size() * 400) @(posedge clock);
    $display("watchdog expired after %0d cycles", table_q.size() * 400);
    $display("Checks failed");
    $finish;
  end

  initial begin
    $timeformat(-9, 0, "", 0);
    seed         = 55400;
    errors       = 0;
    failed_tests = 0;
    model_inv    = '0;
    model_last   = 6'(`MEM_LENGTH - 1);
    for (int d = 0; d < `NUM_DRIVERS; d++) begin
      for (int a = 0; a < `MEM_LENGTH; a++) model_mem[d][a] = '0;
    end
    build_table();
    table_ready = 1;
    wait (arst_n === 1'b1);
    repeat (3) @(posedge clock);
    @(negedge clock);
    assert (driver_io == '0 && !complete && !miso) else begin
      $display("[ERROR] %0t ns outputs after reset: got %h/%b/%b expected 0/0/0",
               $time, driver_io, complete, miso);
      errors++;
    end
    $display("test reset: %s", (errors == 0) ? "ok" : "error");
    if (errors != 0) failed_tests++;
    for (int i = 0; i < table_q.size(); i++) begin
      errs_before = errors;
      if (table_q[i].kind == TRIGGER) begin
        play_trigger(int'(table_q[i].word));
      end else begin
        send_frame(table_q[i].word, (table_q[i].kind == FRAME) ? 32 : 31, rb);
        exp_rb = table_q[i].readback >> ((table_q[i].kind == FRAME) ? 0 : 1);
        assert (rb == exp_rb) else begin
          $display("[ERROR] %0t ns miso_o readback: got %h expected %h",
                   $time, rb, exp_rb);
          errors++;
        end
        if (table_q[i].kind == FRAME) update_model(table_q[i].word);
      end
      if (errors != errs_before) failed_tests++;
      $display("test %0d %s: %s", i, table_q[i].kind.name(),
               (errors == errs_before) ? "ok" : "error");
    end
    $display("tests %0d, tests with errors %0d, check errors %0d",
             table_q.size() + 1, failed_tests, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: verif/tb_clock_gen.sv
/*
 * free-running testbench clock and power-on reset.
 * reset is released with a non-blocking update on a rising edge.
 */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic clock_o,
  output logic arst_n_o
);

  initial begin
    clock_o = 1'b0;
    forever #(PERIOD_NS / 2) clock_o = ~clock_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock_o);
    arst_n_o <= 1'b1;
  end

endmodule
